//--- Bender.yml
package:
  name: rv32iDecode

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/isaPkg.sv
      - rtl/decodePkg.sv
      - rtl/syncFifo.sv
      - rtl/apbFrontend.sv
      - rtl/instrDecoder.sv
      - rtl/decodeReadout.sv
      - rtl/decodeTop.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/decode_props.sv
      - bench/decodeTb.sv

//--- bench/decodeTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_params.svh"

module decodeTb;
    localparam int MAX_TESTS = 32;
    // R-type control word: regWrite set, aluOp FUNCT, no memory access
    localparam logic [31:0] R_CTRL = {21'b0, 1'b0, 2'b00, 2'b10, 6'b100000};

    logic        clk;
    logic        rstN;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pslverr;

    string       names [MAX_TESTS];
    logic [31:0] instrs [MAX_TESTS];
    logic [31:0] expCtrl [MAX_TESTS];
    logic [31:0] expFields [MAX_TESTS];
    logic [31:0] expImm [MAX_TESTS];
    int          numTests;
    int          errors;
    logic [31:0] lcgState;

    decodeTop dut (
        .clk     (clk),
        .rstN    (rstN),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pslverr (pslverr)
    );

    bind decodeTop decodeProps props (
        .clk       (clk),
        .rstN      (rstN),
        .psel      (psel),
        .penable   (penable),
        .pushValid (pushValid),
        .instrFull (instrFull),
        .resValid  (resValid),
        .resReady  (resReady),
        .resData   (resData)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // funct7 picks ADD/SUB style encodings, registers and funct3 are free
    function automatic logic [31:0] makeRtype();
        logic [31:0] r;
        r = nextRand();
        return {(r[31] ? 7'h20 : 7'h00), r[28:24], r[23:19], r[18:16], r[15:11], 7'b0110011};
    endfunction

    // FIELDS layout from bit 0: opcode, rd, funct3, rs1, rs2, funct7
    function automatic logic [31:0] fieldsOf(input logic [31:0] w);
        return {w[31:25], w[24:20], w[19:15], w[14:12], w[11:7], w[6:0]};
    endfunction

    task automatic loadTests();
        int          fd;
        int          n;
        string       line;
        string       nm;
        logic [31:0] a, b, c, d;
        numTests = 0;
        fd = $fopen("bench/decode_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/decode_tests.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin // Skip comment lines
                n = $sscanf(line, "%s %h %h %h %h", nm, a, b, c, d);
                if (n == 5 && numTests < MAX_TESTS) begin
                    names[numTests]     = nm;
                    instrs[numTests]    = a;
                    expCtrl[numTests]   = b;
                    expFields[numTests] = c;
                    expImm[numTests]    = d;
                    numTests++;
                end
            end
        end
        $fclose(fd);
    endtask

    // One APB transfer: setup, then access, then sample after the edge
    task automatic apbXfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
    endtask

    task automatic compareWord(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s %s: expected %08h, actual %08h", name, what, exp, act);
        end
    endtask

    task automatic expectNoErr(input string name, input string what, input logic err);
        if (err !== 1'b0) begin
            errors++;
            $display("%s: unexpected pslverr on %s", name, what);
        end
    endtask

    task automatic waitResult(input string name);
        logic [31:0] val;
        logic        err;
        int          tries;
        val = '0;
        for (tries = 0; tries < 50 && val[0] !== 1'b1; tries++) begin
            apbXfer(1'b0, `ADDR_STATUS, '0, val, err);
        end
        if (val[0] !== 1'b1) begin
            errors++;
            $display("%s: no result showed up in STATUS after 50 polls", name);
        end
    endtask

    // Reads the three result words, then pops the entry
    task automatic verifyHead(input string name, input logic [31:0] expC,
                              input logic [31:0] expF, input logic [31:0] expI);
        logic [31:0] val;
        logic        err;
        apbXfer(1'b0, `ADDR_CTRL, '0, val, err);
        compareWord(name, "ctrl", expC, val);
        expectNoErr(name, "ctrl read", err);
        apbXfer(1'b0, `ADDR_FIELDS, '0, val, err);
        compareWord(name, "fields", expF, val);
        expectNoErr(name, "fields read", err);
        apbXfer(1'b0, `ADDR_IMM, '0, val, err);
        compareWord(name, "imm", expI, val);
        expectNoErr(name, "imm read", err);
        apbXfer(1'b1, `ADDR_POP, '0, val, err);
        expectNoErr(name, "pop", err);
    endtask

    task automatic backPressure();
        logic [31:0] words [9];
        logic [31:0] val;
        logic        err;
        int          k;
        for (k = 0; k < 9; k++) begin // Fills both queues and the decoder slot
            words[k] = makeRtype();
            apbXfer(1'b1, `ADDR_INSTR, words[k], val, err);
            expectNoErr($sformatf("bp push %0d", k), "instruction write", err);
        end
        apbXfer(1'b1, `ADDR_INSTR, 32'h00000013, val, err);
        if (err !== 1'b1) begin
            errors++;
            $display("bp push 9: write to a full instruction queue was not rejected");
        end
        apbXfer(1'b0, `ADDR_STATUS, '0, val, err);
        compareWord("bp full", "status", 32'h3, val);
        for (k = 0; k < 9; k++) begin
            waitResult($sformatf("bp%0d", k));
            verifyHead($sformatf("bp%0d", k), R_CTRL, fieldsOf(words[k]), '0);
        end
    endtask

    initial begin
        logic [31:0] val;
        logic [31:0] word;
        logic        err;
        int          i;
        errors   = 0;
        lcgState = 32'h72b4;
        rstN     = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        loadTests();
        if (numTests == 0) begin
            errors++;
            $display("no test vectors were loaded");
        end
        repeat (8) @(posedge clk);
        rstN <= 1'b1;

        apbXfer(1'b0, `ADDR_STATUS, '0, val, err);
        compareWord("reset", "status", 32'h0, val);
        expectNoErr("reset", "status read", err);
        apbXfer(1'b0, `ADDR_CTRL, '0, val, err);
        compareWord("reset", "ctrl", 32'h0, val);
        if (err !== 1'b1) begin
            errors++;
            $display("reset: ctrl read with no result did not raise pslverr");
        end

        for (i = 0; i < numTests; i++) begin
            apbXfer(1'b1, `ADDR_INSTR, instrs[i], val, err);
            expectNoErr(names[i], "instruction write", err);
            waitResult(names[i]);
            verifyHead(names[i], expCtrl[i], expFields[i], expImm[i]);
        end

        backPressure();

        for (i = 0; i < 20; i++) begin
            word = makeRtype();
            apbXfer(1'b1, `ADDR_INSTR, word, val, err);
            expectNoErr($sformatf("rand%0d", i), "instruction write", err);
            waitResult($sformatf("rand%0d", i));
            verifyHead($sformatf("rand%0d", i), R_CTRL, fieldsOf(word), '0);
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Budget scales with the vector count
    initial begin
        @(posedge rstN);
        repeat ((numTests + 40) * 40) @(posedge clk);
        $display("watchdog expired before the run completed");
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/decode_props.sv
`timescale 1ns/1ps
`default_nettype none

module decodeProps import decodePkg::*; (
    input logic    clk,
    input logic    rstN,
    input logic    psel,
    input logic    penable,
    input logic    pushValid,
    input logic    instrFull,
    input logic    resValid,
    input logic    resReady,
    input decodedT resData
);

    // Access phase must follow a setup cycle
    penableAfterSetup: assert property (@(posedge clk) disable iff (!rstN)
        $rose(penable) |-> psel && $past(psel))
        else $error("penable rose without a psel setup cycle");

    noPushWhenFull: assert property (@(posedge clk) disable iff (!rstN)
        pushValid |-> !instrFull)
        else $error("instruction push while the queue is full");

    // Stalled result must not change
    resDataHeld: assert property (@(posedge clk) disable iff (!rstN)
        resValid && !resReady |=> resValid && $stable(resData))
        else $error("resData changed while stalled");

    resValidLowInReset: assert property (@(posedge clk)
        !rstN |-> !resValid)
        else $error("resValid high during reset");

endmodule

`default_nettype wire

//--- bench/decode_tests.txt
# name instr ctrl fields imm, all hex
# ctrl from bit 0: ctrl[5:0] aluOp[7:6] memOp[9:8] illegal[10]
add_x3_x1_x2   002081B3 000000A0 002081B3 00000000
sub_x5_x6_x7   407302B3 000000A0 407302B3 00000000
addi_pos       00500093 000000B0 00500093 00000005
addi_neg       FFF10113 000000B0 FFF10113 FFFFFFFF
andi_max       7FF1F213 000000B0 7FF1F213 000007FF
lw_pos         0080A283 00000235 0080A283 00000008
lb_neg         FFC10303 00000235 FFC10303 FFFFFFFC
sw_pos         0020A623 00000112 0020A623 0000000C
sb_neg         FE320623 00000112 FE320623 FFFFFFEC
beq_pos        00208863 00000048 00208863 00000010
bne_neg        FE419CE3 00000048 FE419CE3 FFFFFFF8
bge_bit11      0062D0E3 00000048 0062D0E3 00000800
lui_illegal    123450B7 00000400 123450B7 00000000
jal_illegal    0000006F 00000400 0000006F 00000000
zero_illegal   00000000 00000400 00000000 00000000

//--- list.f
+incdir+rtl
rtl/isaPkg.sv
rtl/decodePkg.sv
rtl/syncFifo.sv
rtl/apbFrontend.sv
rtl/instrDecoder.sv
rtl/decodeReadout.sv
rtl/decodeTop.sv
bench/decode_props.sv
bench/decodeTb.sv

//--- rtl/apbFrontend.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_params.svh"

module apbFrontend (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             paddr,
    input  logic [`DATA_WIDTH-1:0] pwdata,
    output logic [`DATA_WIDTH-1:0] prdata,
    output logic                   pslverr,
    output logic                   pushValid,
    output logic [`DATA_WIDTH-1:0] pushData,
    input  logic                   instrFull,
    output logic                   popRes,
    input  logic                   resAvail,
    input  logic [`DATA_WIDTH-1:0] ctrlWord,
    input  logic [`DATA_WIDTH-1:0] fieldsWord,
    input  logic [`DATA_WIDTH-1:0] immWord
);
    logic                   access;
    logic                   wrErr;
    logic                   rdErr;
    logic [`DATA_WIDTH-1:0] rdData;

    assign access = psel && penable; // Access phase, no wait states

    // Write side: only the two strobe registers accept writes
    always_comb begin
        case (paddr)
            `ADDR_INSTR: wrErr = instrFull;  // Dropped when queue is full
            `ADDR_POP:   wrErr = !resAvail;  // Nothing to pop
            default:     wrErr = 1'b1;
        endcase
    end

    // Read side: result words are only valid with an entry at the head
    always_comb begin
        rdData = '0;
        rdErr  = 1'b0;
        case (paddr)
            `ADDR_STATUS: rdData = {{(`DATA_WIDTH - 2){1'b0}}, instrFull, resAvail};
            `ADDR_CTRL: begin
                rdErr  = !resAvail;
                rdData = resAvail ? ctrlWord : '0;
            end
            `ADDR_FIELDS: begin
                rdErr  = !resAvail;
                rdData = resAvail ? fieldsWord : '0;
            end
            `ADDR_IMM: begin
                rdErr  = !resAvail;
                rdData = resAvail ? immWord : '0;
            end
            default: rdErr = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            prdata    <= '0;
            pslverr   <= 1'b0;
            pushValid <= 1'b0;
            popRes    <= 1'b0;
        end else begin
            pushValid <= access && pwrite && (paddr == `ADDR_INSTR) && !wrErr;
            popRes    <= access && pwrite && (paddr == `ADDR_POP) && !wrErr;
            if (access) begin // Held until the next transfer
                pslverr <= pwrite ? wrErr : rdErr;
                prdata  <= pwrite ? '0 : rdData;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access && pwrite) pushData <= pwdata;
    end

endmodule

`default_nettype wire

//--- rtl/decodePkg.sv
`default_nettype none

// Decoded instruction format passed from decoder to readout
package decodePkg;

    import isaPkg::*;

    // Control bundle, regWrite is the MSB
    typedef struct packed {
        logic regWrite;
        logic aluSrc;
        logic branch;
        logic memRead;
        logic memWrite;
        logic memToReg;
    } ctrlT;

    typedef struct packed {
        logic [6:0]  opcode; // Raw, also kept for illegal opcodes
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;    // Sign-extended
        ctrlT        ctrl;
        aluOpT       aluOp;
        memOpT       memOp;
        logic        illegal;
    } decodedT;

endpackage

`default_nettype wire

//--- rtl/decodeReadout.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_params.svh"

module decodeReadout import decodePkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   resValid,
    output logic                   resReady,
    input  decodedT                resData,
    input  logic                   popRes,
    output logic                   resAvail,
    output logic [`DATA_WIDTH-1:0] ctrlWord,
    output logic [`DATA_WIDTH-1:0] fieldsWord,
    output logic [`DATA_WIDTH-1:0] immWord
);
    decodedT head;

    syncFifo #(
        .DEPTH    (`RESULT_DEPTH),
        .payloadT (decodedT)
    ) resFifo (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (resValid),
        .inReady  (resReady), // Drops when full, stalls the decoder
        .inData   (resData),
        .outValid (resAvail),
        .outReady (popRes),
        .outData  (head),
        .full     ()
    );

    // Bit 0 upward: ctrl, aluOp, memOp, illegal
    assign ctrlWord = {{(`DATA_WIDTH - 11){1'b0}}, head.illegal, head.memOp,
                       head.aluOp, head.ctrl};

    // Same bit positions as the raw instruction word
    assign fieldsWord = {head.funct7, head.rs2, head.rs1, head.funct3,
                         head.rd, head.opcode};

    assign immWord = head.imm;

endmodule

`default_nettype wire

//--- rtl/decodeTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_params.svh"

module decodeTop import decodePkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             paddr,
    input  logic [`DATA_WIDTH-1:0] pwdata,
    output logic [`DATA_WIDTH-1:0] prdata,
    output logic                   pslverr
);
    logic                   pushValid;
    logic [`DATA_WIDTH-1:0] pushData;
    logic                   instrFull;
    logic                   instrValid;
    logic                   instrReady;
    logic [`DATA_WIDTH-1:0] instrWord;
    logic                   resValid;
    logic                   resReady;
    decodedT                resData;
    logic                   popRes;
    logic                   resAvail;
    logic [`DATA_WIDTH-1:0] ctrlWord;
    logic [`DATA_WIDTH-1:0] fieldsWord;
    logic [`DATA_WIDTH-1:0] immWord;

    apbFrontend u_apb (
        .clk        (clk),
        .rstN       (rstN),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pslverr    (pslverr),
        .pushValid  (pushValid),
        .pushData   (pushData),
        .instrFull  (instrFull),
        .popRes     (popRes),
        .resAvail   (resAvail),
        .ctrlWord   (ctrlWord),
        .fieldsWord (fieldsWord),
        .immWord    (immWord)
    );

    // Input queue, fullness is judged by the frontend
    syncFifo #(
        .DEPTH    (`INSTR_DEPTH),
        .payloadT (logic [`DATA_WIDTH-1:0])
    ) u_instrFifo (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (pushValid),
        .inReady  (),
        .inData   (pushData),
        .outValid (instrValid),
        .outReady (instrReady),
        .outData  (instrWord),
        .full     (instrFull)
    );

    instrDecoder u_dec (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .instrWord  (instrWord),
        .resValid   (resValid),
        .resReady   (resReady),
        .resData    (resData)
    );

    decodeReadout u_readout (
        .clk        (clk),
        .rstN       (rstN),
        .resValid   (resValid),
        .resReady   (resReady),
        .resData    (resData),
        .popRes     (popRes),
        .resAvail   (resAvail),
        .ctrlWord   (ctrlWord),
        .fieldsWord (fieldsWord),
        .immWord    (immWord)
    );

endmodule

`default_nettype wire

//--- rtl/decode_params.svh
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Bus and instruction word width
`define DATA_WIDTH    32

// Queue depths
`define INSTR_DEPTH   4
`define RESULT_DEPTH  4

// APB register map, byte offsets
`define ADDR_INSTR    8'h00 // Write pushes an instruction
`define ADDR_STATUS   8'h04
`define ADDR_CTRL     8'h08
`define ADDR_FIELDS   8'h0C
`define ADDR_IMM      8'h10
`define ADDR_POP      8'h14 // Write pops the head result

`endif

//--- rtl/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_params.svh"

module instrDecoder
    import isaPkg::*;
    import decodePkg::*;
(
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   instrValid,
    output logic                   instrReady,
    input  logic [`DATA_WIDTH-1:0] instrWord,
    output logic                   resValid,
    input  logic                   resReady,
    output decodedT                resData
);
    opcodeT      opc;
    decodedT     dec;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;

    // Immediate formats, all sign-extended from instr[31]
    assign immI = {{20{instrWord[31]}}, instrWord[31:20]};
    assign immS = {{20{instrWord[31]}}, instrWord[31:25], instrWord[11:7]};
    assign immB = {{19{instrWord[31]}}, instrWord[31], instrWord[7],
                   instrWord[30:25], instrWord[11:8], 1'b0};

    always_comb begin
        opc        = opcodeT'(instrWord[6:0]);
        dec        = '0;
        dec.opcode = instrWord[6:0];
        dec.funct3 = instrWord[14:12];
        dec.funct7 = instrWord[31:25];
        dec.rs1    = instrWord[19:15];
        dec.rs2    = instrWord[24:20];
        dec.rd     = instrWord[11:7];
        // ctrl order: regWrite aluSrc branch memRead memWrite memToReg
        case (opc)
            OP_R: begin
                dec.ctrl  = 6'b100000;
                dec.aluOp = ALU_FUNCT;
            end
            OP_IMM: begin
                dec.ctrl  = 6'b110000;
                dec.aluOp = ALU_FUNCT;
                dec.imm   = immI;
            end
            OP_LOAD: begin
                dec.ctrl  = 6'b110101;
                dec.aluOp = ALU_ADD;
                dec.memOp = MEM_LOAD;
                dec.imm   = immI;
            end
            OP_STORE: begin
                dec.ctrl  = 6'b010010;
                dec.aluOp = ALU_ADD;
                dec.memOp = MEM_STORE;
                dec.imm   = immS;
            end
            OP_BRANCH: begin
                dec.ctrl  = 6'b001000;
                dec.aluOp = ALU_SUB;
                dec.imm   = immB;
            end
            default: dec.illegal = 1'b1; // Controls and imm stay zero
        endcase
    end

    // Single pipeline slot, accepts when empty or draining
    assign instrReady = !resValid || resReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resValid <= 1'b0;
        end else if (instrReady) begin
            resValid <= instrValid;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid && instrReady) resData <= dec;
    end

endmodule

`default_nettype wire

//--- rtl/isaPkg.sv
`default_nettype none

// RV32I encodings recognized by the decoder
package isaPkg;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_STORE  = 7'b0100011,
        OP_R      = 7'b0110011,
        OP_BRANCH = 7'b1100011
    } opcodeT;

    // ALU operation class handed to execute
    typedef enum logic [1:0] {
        ALU_ADD   = 2'b00, // Address calculation
        ALU_SUB   = 2'b01, // Branch compare
        ALU_FUNCT = 2'b10  // Chosen later from funct3/funct7
    } aluOpT;

    // Memory access class
    typedef enum logic [1:0] {
        MEM_NONE  = 2'b00,
        MEM_STORE = 2'b01,
        MEM_LOAD  = 2'b10
    } memOpT;

endpackage

`default_nettype wire

//--- rtl/syncFifo.sv
`timescale 1ns/1ps
`default_nettype none

module syncFifo #(
    parameter int  DEPTH    = 4,
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    inValid,
    output logic    inReady,
    input  payloadT inData,
    output logic    outValid,
    input  logic    outReady,
    output payloadT outData,
    output logic    full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payloadT          mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic             doPush;
    logic             doPop;

    // Wraps at DEPTH so non-power-of-two depths work
    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        nextPtr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full     = (count == CNT_W'(DEPTH));
    assign inReady  = !full;
    assign outValid = (count != '0);
    assign outData  = mem[rdPtr]; // Head is visible without a read strobe
    assign doPush   = inValid && inReady;
    assign doPop    = outValid && outReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) wrPtr <= nextPtr(wrPtr);
            if (doPop) rdPtr <= nextPtr(rdPtr);
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Idle, or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) mem[wrPtr] <= inData;
    end

endmodule

`default_nettype wire
